//--- ex_cfg.svh
// execute stage widths, unit count and multiplier depth
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// data and address width
`define EX_XLEN 32

// destination tag width
`define EX_TAG_W 6

// two alus, load, store and two multiplier issue slots
`define EX_NUM_FU 6

// registered multiplier stages ahead of the result register
`define EX_MULT_STAGES 3

`endif

//--- ex_pkg.sv
// execute stage types for op codes, issue, result, memory request and cdb structs
`default_nettype none

`include "ex_cfg.svh"

package ex_pkg;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_MUL,
        OP_LOAD,
        OP_STORE
    } fu_op_e;

    // one issue slot from the reservation stations
    typedef struct packed {
        logic                 valid;
        fu_op_e               op;
        logic [`EX_TAG_W-1:0] tag;
        logic [`EX_XLEN-1:0]  src1;
        logic [`EX_XLEN-1:0]  src2;
        logic [`EX_XLEN-1:0]  imm;
    } fu_in_t;

    typedef fu_in_t [`EX_NUM_FU-1:0] fu_in_array_t;

    typedef struct packed {
        logic                 valid;
        logic [`EX_TAG_W-1:0] tag;
        logic [`EX_XLEN-1:0]  value;
    } fu_out_t;

    typedef fu_out_t [`EX_NUM_FU-1:0] fu_out_array_t;

    typedef struct packed {
        logic                valid;
        logic                write;
        logic [`EX_XLEN-1:0] addr;
        logic [`EX_XLEN-1:0] wdata;
    } mem_req_t;

    // single broadcast per cycle
    typedef struct packed {
        logic                 valid;
        logic [`EX_TAG_W-1:0] tag;
        logic [`EX_XLEN-1:0]  value;
    } cdb_t;

endpackage

`default_nettype wire

//--- result_hold.sv
// holding register that keeps one payload of any type until ack
`timescale 1ns/1ps
`default_nettype none

module result_hold #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     load,
    input  payload_t din,
    input  logic     ack,
    output payload_t dout,
    output logic     full
);

    // load wins over ack on the same edge
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (ack) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            dout <= din;
        end
    end

endmodule

`default_nettype wire

//--- alu_fu.sv
// single-cycle integer alu unit with a held result
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module alu_fu import ex_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    input  fu_in_t  fu_in,
    input  logic    ack,
    output fu_out_t fu_out,
    output logic    fu_ready
);

    logic [`EX_XLEN-1:0] res;
    logic                accept;
    logic                full;
    fu_out_t             held;

    // slot frees up in the same cycle it is acked
    assign fu_ready = !full || ack;
    assign accept   = fu_in.valid && fu_ready;

    always_comb begin
        case (fu_in.op)
            OP_ADD:  res = fu_in.src1 + fu_in.src2;
            OP_SUB:  res = fu_in.src1 - fu_in.src2;
            OP_AND:  res = fu_in.src1 & fu_in.src2;
            OP_OR:   res = fu_in.src1 | fu_in.src2;
            OP_XOR:  res = fu_in.src1 ^ fu_in.src2;
            OP_SLT:  res = {{(`EX_XLEN-1){1'b0}}, $signed(fu_in.src1) < $signed(fu_in.src2)};
            OP_SLL:  res = fu_in.src1 << fu_in.src2[4:0];
            OP_SRL:  res = fu_in.src1 >> fu_in.src2[4:0];
            default: res = '0;
        endcase
    end

    result_hold #(.payload_t(fu_out_t)) hold_inst (
        .clock (clock),
        .rst_n (rst_n),
        .load  (accept),
        .din   ('{valid: 1'b1, tag: fu_in.tag, value: res}),
        .ack   (ack),
        .dout  (held),
        .full  (full)
    );

    // valid comes from the hold flag, payload from the register
    always_comb begin
        fu_out       = held;
        fu_out.valid = full;
    end

endmodule

`default_nettype wire

//--- mult_fu.sv
// pipelined low-word multiplier unit that stalls on a held output
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module mult_fu import ex_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    input  fu_in_t  fu_in,
    input  logic    ack,
    output fu_out_t fu_out,
    output logic    fu_ready
);

    localparam int S     = `EX_MULT_STAGES;
    localparam int CHUNK = (`EX_XLEN + S - 1) / S;
    localparam logic [`EX_XLEN-1:0] CHUNK_MASK = {{(`EX_XLEN-CHUNK){1'b0}}, {CHUNK{1'b1}}};

    logic [S-1:0]         st_valid;
    logic [`EX_TAG_W-1:0] st_tag [S];
    logic [`EX_XLEN-1:0]  st_acc [S];
    // operands only needed by the stages that still add a chunk
    logic [`EX_XLEN-1:0]  op_a [S-1];
    logic [`EX_XLEN-1:0]  op_b [S-1];
    logic                 full;
    logic                 stall;
    logic                 advance;
    logic                 accept;
    fu_out_t              held;

    // src1 times one chunk of src2, shifted into place
    function automatic logic [`EX_XLEN-1:0] part_prod(
        input logic [`EX_XLEN-1:0] a,
        input logic [`EX_XLEN-1:0] b,
        input int                  idx
    );
        logic [`EX_XLEN-1:0] b_chunk;
        b_chunk = (b >> (idx * CHUNK)) & CHUNK_MASK;
        return (a * b_chunk) << (idx * CHUNK);
    endfunction

    assign stall    = st_valid[S-1] && full && !ack;
    assign advance  = !stall;
    assign fu_ready = advance;
    assign accept   = fu_in.valid && fu_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            st_valid <= '0;
        end else if (advance) begin
            st_valid <= {st_valid[S-2:0], accept};
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            st_tag[0] <= fu_in.tag;
            st_acc[0] <= part_prod(fu_in.src1, fu_in.src2, 0);
            op_a[0]   <= fu_in.src1;
            op_b[0]   <= fu_in.src2;
            for (int i = 1; i < S; i++) begin
                st_tag[i] <= st_tag[i-1];
                st_acc[i] <= st_acc[i-1] + part_prod(op_a[i-1], op_b[i-1], i);
            end
            for (int i = 1; i < S - 1; i++) begin
                op_a[i] <= op_a[i-1];
                op_b[i] <= op_b[i-1];
            end
        end
    end

    result_hold #(.payload_t(fu_out_t)) hold_inst (
        .clock (clock),
        .rst_n (rst_n),
        .load  (st_valid[S-1] && advance),
        .din   ('{valid: 1'b1, tag: st_tag[S-1], value: st_acc[S-1]}),
        .ack   (ack),
        .dout  (held),
        .full  (full)
    );

    always_comb begin
        fu_out       = held;
        fu_out.valid = full;
    end

endmodule

`default_nettype wire

//--- load_fu.sv
// load unit with address generation, memory port request and read data capture
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module load_fu import ex_pkg::*; (
    input  logic                clock,
    input  logic                rst_n,
    input  fu_in_t              fu_in,
    input  logic                ack,
    input  logic                mem_grant,
    input  logic [`EX_XLEN-1:0] mem_rdata,
    output fu_out_t             fu_out,
    output mem_req_t            mem_req,
    output logic                fu_ready
);

    logic                 req_pending;
    logic [`EX_XLEN-1:0]  addr_q;
    logic [`EX_TAG_W-1:0] tag_q;
    logic                 accept;
    logic                 full;
    fu_out_t              held;

    // one load at a time and busy until the result leaves
    assign fu_ready = !req_pending && !full;
    assign accept   = fu_in.valid && fu_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            req_pending <= 1'b0;
        end else if (accept) begin
            req_pending <= 1'b1;
        end else if (mem_grant) begin
            req_pending <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q <= fu_in.src1 + fu_in.imm;
            tag_q  <= fu_in.tag;
        end
    end

    assign mem_req = '{valid: req_pending, write: 1'b0, addr: addr_q, wdata: '0};

    // read data is combinational, so it is taken at the grant edge
    result_hold #(.payload_t(fu_out_t)) hold_inst (
        .clock (clock),
        .rst_n (rst_n),
        .load  (req_pending && mem_grant),
        .din   ('{valid: 1'b1, tag: tag_q, value: mem_rdata}),
        .ack   (ack),
        .dout  (held),
        .full  (full)
    );

    always_comb begin
        fu_out       = held;
        fu_out.valid = full;
    end

endmodule

`default_nettype wire

//--- store_fu.sv
// store unit with address generation, memory write request and completion result
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module store_fu import ex_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  fu_in_t   fu_in,
    input  logic     ack,
    input  logic     mem_grant,
    output fu_out_t  fu_out,
    output mem_req_t mem_req,
    output logic     fu_ready
);

    logic                 req_pending;
    logic [`EX_XLEN-1:0]  addr_q;
    logic [`EX_XLEN-1:0]  wdata_q;
    logic [`EX_TAG_W-1:0] tag_q;
    logic                 accept;
    logic                 full;
    fu_out_t              held;

    assign fu_ready = !req_pending && !full;
    assign accept   = fu_in.valid && fu_ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            req_pending <= 1'b0;
        end else if (accept) begin
            req_pending <= 1'b1;
        end else if (mem_grant) begin
            req_pending <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= fu_in.src1 + fu_in.imm;
            wdata_q <= fu_in.src2;
            tag_q   <= fu_in.tag;
        end
    end

    assign mem_req = '{valid: req_pending, write: 1'b1, addr: addr_q, wdata: wdata_q};

    // write lands at the grant edge and the completion carries value zero
    result_hold #(.payload_t(fu_out_t)) hold_inst (
        .clock (clock),
        .rst_n (rst_n),
        .load  (req_pending && mem_grant),
        .din   ('{valid: 1'b1, tag: tag_q, value: '0}),
        .ack   (ack),
        .dout  (held),
        .full  (full)
    );

    always_comb begin
        fu_out       = held;
        fu_out.valid = full;
    end

endmodule

`default_nettype wire

//--- cdb_select.sv
// fixed-priority cdb selector with per-unit ack
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module cdb_select import ex_pkg::*; (
    input  fu_out_array_t         fu_out,
    output logic [`EX_NUM_FU-1:0] ack,
    output cdb_t                  cdb
);

    // lowest index wins
    always_comb begin
        logic found;
        found = 1'b0;
        ack   = '0;
        cdb   = '0;
        for (int i = 0; i < `EX_NUM_FU; i++) begin
            if (!found && fu_out[i].valid) begin
                found     = 1'b1;
                ack[i]    = 1'b1;
                cdb.valid = 1'b1;
                cdb.tag   = fu_out[i].tag;
                cdb.value = fu_out[i].value;
            end
        end
    end

endmodule

`default_nettype wire

//--- ex.sv
// execute stage top with unit instances, memory port arbitration and cdb
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module ex import ex_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  fu_in_array_t          issue,
    input  logic [`EX_XLEN-1:0]   mem_rdata,
    output logic [`EX_NUM_FU-1:0] fu_ready,
    output mem_req_t              mem_req,
    output cdb_t                  cdb
);

    fu_out_array_t         fu_out;
    logic [`EX_NUM_FU-1:0] ack;
    mem_req_t              ld_req;
    mem_req_t              st_req;
    logic                  ld_grant;
    logic                  st_grant;

    // load has priority at the memory port
    assign ld_grant = ld_req.valid;
    assign st_grant = st_req.valid && !ld_req.valid;
    assign mem_req  = ld_grant ? ld_req : (st_grant ? st_req : '0);

    alu_fu alu0_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .fu_in    (issue[0]),
        .ack      (ack[0]),
        .fu_out   (fu_out[0]),
        .fu_ready (fu_ready[0])
    );

    alu_fu alu1_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .fu_in    (issue[1]),
        .ack      (ack[1]),
        .fu_out   (fu_out[1]),
        .fu_ready (fu_ready[1])
    );

    load_fu load_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .fu_in     (issue[2]),
        .ack       (ack[2]),
        .mem_grant (ld_grant),
        .mem_rdata (mem_rdata),
        .fu_out    (fu_out[2]),
        .mem_req   (ld_req),
        .fu_ready  (fu_ready[2])
    );

    store_fu store_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .fu_in     (issue[3]),
        .ack       (ack[3]),
        .mem_grant (st_grant),
        .fu_out    (fu_out[3]),
        .mem_req   (st_req),
        .fu_ready  (fu_ready[3])
    );

    mult_fu mult0_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .fu_in    (issue[4]),
        .ack      (ack[4]),
        .fu_out   (fu_out[4]),
        .fu_ready (fu_ready[4])
    );

    mult_fu mult1_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .fu_in    (issue[5]),
        .ack      (ack[5]),
        .fu_out   (fu_out[5]),
        .fu_ready (fu_ready[5])
    );

    cdb_select cdb_select_inst (
        .fu_out (fu_out),
        .ack    (ack),
        .cdb    (cdb)
    );

endmodule

`default_nettype wire

//--- tb_ex.sv
// execute stage testbench with an operation table, memory model and cdb tag scoreboard
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module tb_ex import ex_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int MAX_ROWS   = 1 << `EX_TAG_W;
    localparam int MEM_WORDS  = 256;

    typedef struct packed {
        logic [2:0]           slot;
        fu_op_e               op;
        logic [`EX_TAG_W-1:0] tag;
        logic [`EX_XLEN-1:0]  src1;
        logic [`EX_XLEN-1:0]  src2;
        logic [`EX_XLEN-1:0]  imm;
        logic [`EX_XLEN-1:0]  expected;
        logic                 with_prev;
        logic                 drain;
    } row_t;

    logic                  clock;
    logic                  rst_n;
    fu_in_array_t          issue;
    logic [`EX_XLEN-1:0]   mem_rdata;
    logic [`EX_NUM_FU-1:0] fu_ready;
    mem_req_t              mem_req;
    cdb_t                  cdb;

    row_t                rows [MAX_ROWS];
    string               row_name [MAX_ROWS];
    logic                issued [MAX_ROWS];
    int                  seen [MAX_ROWS];
    logic [`EX_XLEN-1:0] shadow [MEM_WORDS];
    logic [`EX_XLEN-1:0] mem [MEM_WORDS];
    int                  row_count;
    int                  issue_count;
    int                  result_count;
    logic                table_done = 1'b0;

    ex ex_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .issue     (issue),
        .mem_rdata (mem_rdata),
        .fu_ready  (fu_ready),
        .mem_req   (mem_req),
        .cdb       (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [`EX_XLEN-1:0] init_word(input int idx);
        return 32'h1000 + idx;
    endfunction

    // reference alu results with slt as a two's complement compare
    function automatic logic [`EX_XLEN-1:0] alu_model(
        input fu_op_e              op,
        input logic [`EX_XLEN-1:0] a,
        input logic [`EX_XLEN-1:0] b
    );
        logic lt;
        lt = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return {31'b0, lt};
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            default: return '0;
        endcase
    endfunction

    task automatic check_value(
        input string               name,
        input logic [`EX_XLEN-1:0] expected,
        input logic [`EX_XLEN-1:0] actual
    );
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // expected value follows the shadow memory in table order
    task automatic add_row(
        input logic [2:0]          slot,
        input fu_op_e              op,
        input logic [`EX_XLEN-1:0] src1,
        input logic [`EX_XLEN-1:0] src2,
        input logic [`EX_XLEN-1:0] imm,
        input logic                with_prev,
        input logic                drain
    );
        logic [`EX_XLEN-1:0] addr;
        logic [`EX_XLEN-1:0] value;
        addr = src1 + imm;
        case (op)
            OP_MUL:  value = src1 * src2;
            OP_LOAD: value = shadow[addr[9:2]];
            OP_STORE: begin
                value = '0;
                shadow[addr[9:2]] = src2;
            end
            default: value = alu_model(op, src1, src2);
        endcase
        rows[row_count] = '{slot: slot, op: op, tag: row_count[`EX_TAG_W-1:0],
                            src1: src1, src2: src2, imm: imm, expected: value,
                            with_prev: with_prev, drain: drain};
        row_name[row_count] = $sformatf("row %0d %s slot %0d", row_count, op.name(), slot);
        row_count++;
    endtask

    task automatic build_table();
        fu_op_e op;
        // every alu op on both alus in the same cycle
        for (int n = 0; n <= 7; n++) begin
            op = fu_op_e'(n);
            add_row(3'd0, op, $urandom(), $urandom(), '0, 1'b0, 1'b0);
            add_row(3'd1, op, $urandom(), $urandom(), '0, 1'b1, 1'b0);
        end
        add_row(3'd1, OP_SLT, 32'hffff_fff0, 32'h5, '0, 1'b0, 1'b0);
        add_row(3'd1, OP_SLT, 32'h5, 32'hffff_fff0, '0, 1'b0, 1'b0);
        add_row(3'd1, OP_SLL, 32'h1, 32'd35, '0, 1'b0, 1'b0);
        add_row(3'd1, OP_SRL, 32'h8000_0000, 32'd31, '0, 1'b0, 1'b0);
        // back to back multiplies
        for (int n = 0; n < 4; n++) begin
            add_row(3'd4, OP_MUL, $urandom(), $urandom(), '0, 1'b0, 1'b0);
        end
        add_row(3'd5, OP_MUL, 32'hffff_ffff, 32'hffff_ffff, '0, 1'b0, 1'b0);
        add_row(3'd5, OP_MUL, 32'h1234_5678, 32'h9abc_def0, '0, 1'b0, 1'b0);
        add_row(3'd2, OP_LOAD, 32'h40, '0, 32'h8, 1'b0, 1'b0);
        // store, then read it back once its completion is seen
        add_row(3'd3, OP_STORE, 32'h100, 32'hdead_beef, 32'h4, 1'b0, 1'b1);
        add_row(3'd2, OP_LOAD, 32'h100, '0, 32'h4, 1'b0, 1'b1);
        // all six slots at once
        add_row(3'd0, OP_ADD, $urandom(), $urandom(), '0, 1'b0, 1'b1);
        add_row(3'd1, OP_XOR, $urandom(), $urandom(), '0, 1'b1, 1'b0);
        add_row(3'd2, OP_LOAD, 32'h20, '0, 32'hc, 1'b1, 1'b0);
        add_row(3'd3, OP_STORE, 32'h200, $urandom(), '0, 1'b1, 1'b0);
        add_row(3'd4, OP_MUL, $urandom(), $urandom(), '0, 1'b1, 1'b0);
        add_row(3'd5, OP_MUL, $urandom(), $urandom(), '0, 1'b1, 1'b0);
        // load and store together on the shared port
        add_row(3'd2, OP_LOAD, 32'h80, '0, '0, 1'b0, 1'b1);
        add_row(3'd3, OP_STORE, 32'h300, $urandom(), 32'h10, 1'b1, 1'b0);
    endtask

    // memory model with combinational reads and writes at the edge
    assign mem_rdata = mem[mem_req.addr[9:2]];

    initial begin
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[k] = init_word(k);
        end
        forever begin
            @(posedge clock);
            if (mem_req.valid && mem_req.write) begin
                mem[mem_req.addr[9:2]] = mem_req.wdata;
            end
        end
    end

    // cdb scoreboard sampled mid cycle
    always @(negedge clock) begin
        if (rst_n && cdb.valid) begin
            check_value("cdb tag issued", 32'd1, {31'b0, issued[cdb.tag]});
            check_value(row_name[cdb.tag], rows[cdb.tag].expected, cdb.value);
            seen[cdb.tag]++;
            result_count++;
        end
    end

    initial begin
        wait (table_done);
        #((row_count * 20 + 10) * CLK_PERIOD);
        $display("timeout: %0d results never reached the cdb", issue_count - result_count);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int                  i;
        int                  j;
        logic                ok;
        logic [`EX_XLEN-1:0] addr;
        rst_n       = 1'b0;
        issue       = '0;
        row_count   = 0;
        issue_count = 0;
        void'($urandom(32'h252d));
        for (int k = 0; k < MAX_ROWS; k++) begin
            issued[k] = 1'b0;
        end
        for (int k = 0; k < MEM_WORDS; k++) begin
            shadow[k] = init_word(k);
        end
        build_table();
        table_done = 1'b1;
        repeat (10) @(posedge clock);
        #2;
        check_value("fu_ready after reset",
                    {{(`EX_XLEN-`EX_NUM_FU){1'b0}}, {`EX_NUM_FU{1'b1}}},
                    {{(`EX_XLEN-`EX_NUM_FU){1'b0}}, fu_ready});
        check_value("cdb valid after reset", 32'd0, {31'b0, cdb.valid});
        check_value("mem_req valid after reset", 32'd0, {31'b0, mem_req.valid});
        rst_n = 1'b1;
        i = 0;
        while (i < row_count) begin
            // rows joined to the previous one go out in the same cycle
            j = i + 1;
            while (j < row_count && rows[j].with_prev) begin
                j++;
            end
            // multipliers take a new operation every cycle while their output drains
            for (int k = i; k < j; k++) begin
                if (rows[k].op == OP_MUL) begin
                    check_value({row_name[k], " pipelined ready"}, 32'd1,
                                {31'b0, fu_ready[rows[k].slot]});
                end
            end
            ok = 1'b0;
            while (!ok) begin
                ok = !(rows[i].drain && issue_count != result_count);
                for (int k = i; k < j; k++) begin
                    if (!fu_ready[rows[k].slot]) begin
                        ok = 1'b0;
                    end
                end
                if (!ok) begin
                    @(posedge clock);
                    #2;
                end
            end
            for (int k = i; k < j; k++) begin
                issue[rows[k].slot] = '{valid: 1'b1, op: rows[k].op, tag: rows[k].tag,
                                        src1: rows[k].src1, src2: rows[k].src2,
                                        imm: rows[k].imm};
                issued[rows[k].tag] = 1'b1;
                issue_count++;
            end
            @(posedge clock);
            #2;
            issue = '0;
            i = j;
        end
        wait (issue_count == result_count);
        repeat (5) @(posedge clock);
        for (int k = 0; k < row_count; k++) begin
            check_value({row_name[k], " tag count"}, 32'd1, seen[k]);
            if (rows[k].op == OP_STORE) begin
                addr = rows[k].src1 + rows[k].imm;
                check_value({row_name[k], " memory word"}, rows[k].src2, mem[addr[9:2]]);
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
ex_pkg.sv
result_hold.sv
alu_fu.sv
mult_fu.sv
load_fu.sv
store_fu.sv
cdb_select.sv
ex.sv
tb_ex.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f flist.f --top-module tb_ex --Mdir obj_dir -o tb_ex_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_ex_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
